//--- files.f
rtl/issue_pkg.sv
rtl/dispatch_queue.sv
rtl/alu_issue.sv
rtl/alu_unit.sv
rtl/result_arbiter.sv
rtl/issue_core.sv
testbench/tb_issue_core.sv

//--- rtl/alu_issue.sv
// ==============================
// Age ordered ALU selector, purely combinational
// Scans the queue from the head and hands up to one entry to each idle ALU,
// never letting an entry pass an older sync that still has older work
// ==============================
`timescale 1ns/10ps
`default_nettype none

module alu_issue (
	input  wire                                            alu0_idle,
	input  wire                                            alu1_idle,
	input  wire issue_pkg::que_bitmask_t                   could_issue,
	input  wire issue_pkg::que_ndx_t                       head0,
	input  wire issue_pkg::que_ndx_t                       head1,
	input  wire issue_pkg::que_ndx_t                       head2,
	input  wire issue_pkg::que_ndx_t                       head3,
	input  wire issue_pkg::que_ndx_t                       head4,
	input  wire issue_pkg::que_ndx_t                       head5,
	input  wire issue_pkg::que_ndx_t                       head6,
	input  wire issue_pkg::que_ndx_t                       head7,
	input  wire issue_pkg::iq_entry_t [issue_pkg::QENTRIES-1:0] iq,
	output issue_pkg::que_bitmask_t                        iqentry_issue,
	output issue_pkg::islot_t                              iqentry_islot [0:issue_pkg::QENTRIES-1]
);

	// Queue index at each age position, oldest first
	issue_pkg::que_ndx_t hd [0:issue_pkg::QENTRIES-1];
	// Both vectors below are indexed by age position, not by queue index
	logic [issue_pkg::QENTRIES-1:0] blocked;
	logic [issue_pkg::QENTRIES-1:0] eligible;

	assign hd[0] = head0;
	assign hd[1] = head1;
	assign hd[2] = head2;
	assign hd[3] = head3;
	assign hd[4] = head4;
	assign hd[5] = head5;
	assign hd[6] = head6;
	assign hd[7] = head7;

	// ==============================
	// Sync barrier
	// ==============================
	// A valid sync at position j fences off every younger position while
	// anything older than j is still in the queue
	// At j = 0 nothing is older, so the head sync never fences
	always_comb begin
		logic older_v;
		logic barrier;
		older_v = 1'b0;
		barrier = 1'b0;
		for (int k = 0; k < issue_pkg::QENTRIES; k++) begin
			blocked[k] = barrier;
			if (iq[hd[k]].v && iq[hd[k]].instr.sync && older_v)
				barrier = 1'b1;
			older_v = older_v | iq[hd[k]].v;
		end
	end

	always_comb begin
		for (int k = 0; k < issue_pkg::QENTRIES; k++)
			eligible[k] = could_issue[hd[k]] && iq[hd[k]].alu && !blocked[k];
	end

	// ==============================
	// Slot assignment
	// ==============================
	// The second pass skips whatever the first pass took, so the two
	// oldest eligible entries go out together when both ALUs are idle
	always_comb begin
		logic found0;
		logic found1;
		found0 = 1'b0;
		found1 = 1'b0;
		iqentry_issue = '0;
		for (int n = 0; n < issue_pkg::QENTRIES; n++)
			iqentry_islot[n] = 2'd0;
		for (int k = 0; k < issue_pkg::QENTRIES; k++) begin
			if (alu0_idle && !found0 && eligible[k]) begin
				found0 = 1'b1;
				iqentry_issue[hd[k]] = 1'b1;
				iqentry_islot[hd[k]] = 2'd0;
			end
		end
		for (int k = 0; k < issue_pkg::QENTRIES; k++) begin
			if (alu1_idle && !found1 && eligible[k] && !iqentry_issue[hd[k]]) begin
				found1 = 1'b1;
				iqentry_issue[hd[k]] = 1'b1;
				iqentry_islot[hd[k]] = 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/alu_unit.sv
// ==============================
// One ALU with a result holding register
// Simple ops land in the holding register at the issue edge, a divide
// iterates for DIV_CYCLES cycles before its quotient is held
// ==============================
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire issue_pkg::issue_t   issue,
	input  wire                      take,
	output logic                     idle,
	output issue_pkg::result_t       result
);

	localparam int W = issue_pkg::DATA_W;

	// Divider state, remainder one bit wider than the operands
	logic [W:0] rem;
	logic [W-1:0] quo;
	logic [W-1:0] den;
	logic div_busy;
	logic [$clog2(issue_pkg::DIV_CYCLES)-1:0] div_cnt;
	issue_pkg::que_ndx_t div_ndx;
	logic [issue_pkg::TAG_W-1:0] div_tag;

	logic start_div;
	logic div_fin;
	logic hold_free;
	logic [W-1:0] simple_val;
	logic [W-1:0] den_sel;
	logic [2*W:0] step_in;
	logic [2*W:0] step_out;

	// DIV_BITS restoring steps on a packed {remainder, quotient} pair
	// A zero divisor always passes the compare, so the quotient fills with ones
	function automatic logic [2*W:0] div_step(input logic [2*W:0] rq, input logic [W-1:0] d);
		logic [W:0] r;
		logic [W-1:0] q;
		{r, q} = rq;
		for (int i = 0; i < issue_pkg::DIV_BITS; i++) begin
			r = {r[W-1:0], q[W-1]};
			q = {q[W-2:0], 1'b0};
			if (r >= {1'b0, d}) begin
				r = r - {1'b0, d};
				q[0] = 1'b1;
			end
		end
		return {r, q};
	endfunction

	assign start_div = issue.v && issue.instr.op == issue_pkg::OP_DIV;
	// Counter at zero means all quotient bits are resolved
	assign div_fin = div_busy && div_cnt == '0;
	assign hold_free = !result.v || take;
	assign idle = !div_busy && hold_free;

	// The first step already runs in the issue cycle
	assign step_in = start_div ? {{(W+1){1'b0}}, issue.instr.a} : {rem, quo};
	assign den_sel = start_div ? issue.instr.b : den;
	assign step_out = div_step(step_in, den_sel);

	always_comb begin
		case (issue.instr.op)
			issue_pkg::OP_ADD: simple_val = issue.instr.a + issue.instr.b;
			issue_pkg::OP_SUB: simple_val = issue.instr.a - issue.instr.b;
			issue_pkg::OP_AND: simple_val = issue.instr.a & issue.instr.b;
			issue_pkg::OP_XOR: simple_val = issue.instr.a ^ issue.instr.b;
			default: simple_val = issue.instr.a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result.v <= 1'b0;
			div_busy <= 1'b0;
			div_cnt <= '0;
		end else begin
			if (start_div) begin
				div_busy <= 1'b1;
				div_cnt <= $bits(div_cnt)'(issue_pkg::DIV_CYCLES - 1);
				{rem, quo} <= step_out;
				den <= issue.instr.b;
				div_ndx <= issue.ndx;
				div_tag <= issue.instr.tag;
			end else if (div_busy && div_cnt != '0) begin
				{rem, quo} <= step_out;
				div_cnt <= div_cnt - 1'b1;
			end
			// Holding register; a finished quotient waits here if still occupied
			if (issue.v && !start_div) begin
				result <= '{v: 1'b1, ndx: issue.ndx, tag: issue.instr.tag,
					value: simple_val};
			end else if (div_fin && hold_free) begin
				result <= '{v: 1'b1, ndx: div_ndx, tag: div_tag, value: quo};
				div_busy <= 1'b0;
			end else if (take) begin
				result.v <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/dispatch_queue.sv
// ==============================
// Eight-entry circular issue queue
// New instructions go in at the tail, done entries retire in order from
// the head, and each retirement pulses one dispatch credit back
// ==============================
`timescale 1ns/10ps
`default_nettype none

module dispatch_queue (
	input  wire                                               clk,
	input  wire                                               rst_n,
	input  wire                                               dispatch_v,
	input  wire issue_pkg::instr_t                            dispatch_in,
	input  wire issue_pkg::que_bitmask_t                      iqentry_issue,
	input  wire issue_pkg::islot_t                            iqentry_islot [0:issue_pkg::QENTRIES-1],
	input  wire                                               done_v,
	input  wire issue_pkg::que_ndx_t                          done_ndx,
	output issue_pkg::iq_entry_t [issue_pkg::QENTRIES-1:0]    iq,
	output issue_pkg::que_ndx_t                               head0,
	output issue_pkg::que_ndx_t                               head1,
	output issue_pkg::que_ndx_t                               head2,
	output issue_pkg::que_ndx_t                               head3,
	output issue_pkg::que_ndx_t                               head4,
	output issue_pkg::que_ndx_t                               head5,
	output issue_pkg::que_ndx_t                               head6,
	output issue_pkg::que_ndx_t                               head7,
	output issue_pkg::que_bitmask_t                           could_issue,
	output issue_pkg::issue_t                                 alu0_issue,
	output issue_pkg::issue_t                                 alu1_issue,
	output logic                                              dispatch_credit
);

	issue_pkg::que_ndx_t head;
	issue_pkg::que_ndx_t tail;
	// Issue record per ALU, indexed by slot number
	issue_pkg::issue_t slot_issue [0:issue_pkg::NALU-1];
	logic retire;

	// Age order positions; the 3 bit index wraps around the ring by itself
	assign head0 = head;
	assign head1 = head + 3'd1;
	assign head2 = head + 3'd2;
	assign head3 = head + 3'd3;
	assign head4 = head + 3'd4;
	assign head5 = head + 3'd5;
	assign head6 = head + 3'd6;
	assign head7 = head + 3'd7;

	// Only the oldest entry may leave, and only once its result is out
	assign retire = iq[head].v && iq[head].done;

	// An entry is a candidate until it has been handed to an ALU
	always_comb begin
		for (int n = 0; n < issue_pkg::QENTRIES; n++)
			could_issue[n] = iq[n].v && !iq[n].issued;
	end

	// Gather the selected entry for each ALU slot
	// The selector never picks two entries for one slot
	always_comb begin
		for (int s = 0; s < issue_pkg::NALU; s++) begin
			slot_issue[s] = '0;
			for (int n = 0; n < issue_pkg::QENTRIES; n++) begin
				if (iqentry_issue[n] && iqentry_islot[n] == issue_pkg::islot_t'(s)) begin
					slot_issue[s].v = 1'b1;
					slot_issue[s].ndx = issue_pkg::que_ndx_t'(n);
					slot_issue[s].instr = iq[n].instr;
				end
			end
		end
	end

	assign alu0_issue = slot_issue[0];
	assign alu1_issue = slot_issue[1];

	// ==============================
	// Queue state
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			dispatch_credit <= 1'b0;
			for (int n = 0; n < issue_pkg::QENTRIES; n++) begin
				iq[n].v <= 1'b0;
				iq[n].issued <= 1'b0;
				iq[n].done <= 1'b0;
			end
		end else begin
			// One credit per freed slot, seen in the cycle after retirement
			dispatch_credit <= retire;
			for (int n = 0; n < issue_pkg::QENTRIES; n++) begin
				if (iqentry_issue[n])
					iq[n].issued <= 1'b1;
			end
			// The arbiter names the slot whose result just left
			if (done_v)
				iq[done_ndx].done <= 1'b1;
			if (retire) begin
				iq[head].v <= 1'b0;
				head <= head + 3'd1;
			end
			// Credit flow keeps the tail off a live entry
			if (dispatch_v) begin
				iq[tail] <= '{v: 1'b1, issued: 1'b0, done: 1'b0, alu: 1'b1,
					instr: dispatch_in};
				tail <= tail + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/issue_core.sv
// ==============================
// ALU issue stage top level
// Queue, selector, two ALUs and the writeback arbiter, wired together
// ==============================
`timescale 1ns/10ps
`default_nettype none

module issue_core (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       dispatch_v,
	input  wire issue_pkg::instr_t    dispatch_in,
	output logic                      dispatch_credit,
	input  wire                       wb_credit,
	output issue_pkg::result_t        result_out
);

	// Queue to selector
	issue_pkg::iq_entry_t [issue_pkg::QENTRIES-1:0] iq;
	issue_pkg::que_ndx_t head0;
	issue_pkg::que_ndx_t head1;
	issue_pkg::que_ndx_t head2;
	issue_pkg::que_ndx_t head3;
	issue_pkg::que_ndx_t head4;
	issue_pkg::que_ndx_t head5;
	issue_pkg::que_ndx_t head6;
	issue_pkg::que_ndx_t head7;
	issue_pkg::que_bitmask_t could_issue;

	// Selector back to queue
	issue_pkg::que_bitmask_t iqentry_issue;
	issue_pkg::islot_t iqentry_islot [0:issue_pkg::QENTRIES-1];

	// ALU side
	issue_pkg::issue_t alu0_issue;
	issue_pkg::issue_t alu1_issue;
	logic alu0_idle;
	logic alu1_idle;
	logic alu0_take;
	logic alu1_take;
	issue_pkg::result_t alu0_result;
	issue_pkg::result_t alu1_result;

	// Writeback back to queue
	logic done_v;
	issue_pkg::que_ndx_t done_ndx;

	dispatch_queue u_queue (
		.clk(clk), .rst_n(rst_n),
		.dispatch_v(dispatch_v), .dispatch_in(dispatch_in),
		.iqentry_issue(iqentry_issue), .iqentry_islot(iqentry_islot),
		.done_v(done_v), .done_ndx(done_ndx),
		.iq(iq),
		.head0(head0), .head1(head1), .head2(head2), .head3(head3),
		.head4(head4), .head5(head5), .head6(head6), .head7(head7),
		.could_issue(could_issue),
		.alu0_issue(alu0_issue), .alu1_issue(alu1_issue),
		.dispatch_credit(dispatch_credit)
	);

	alu_issue u_select (
		.alu0_idle(alu0_idle), .alu1_idle(alu1_idle),
		.could_issue(could_issue),
		.head0(head0), .head1(head1), .head2(head2), .head3(head3),
		.head4(head4), .head5(head5), .head6(head6), .head7(head7),
		.iq(iq),
		.iqentry_issue(iqentry_issue), .iqentry_islot(iqentry_islot)
	);

	alu_unit alu0 (
		.clk(clk), .rst_n(rst_n), .issue(alu0_issue), .take(alu0_take),
		.idle(alu0_idle), .result(alu0_result)
	);

	alu_unit alu1 (
		.clk(clk), .rst_n(rst_n), .issue(alu1_issue), .take(alu1_take),
		.idle(alu1_idle), .result(alu1_result)
	);

	result_arbiter u_arb (
		.clk(clk), .rst_n(rst_n),
		.alu0_result(alu0_result), .alu1_result(alu1_result),
		.wb_credit(wb_credit),
		.alu0_take(alu0_take), .alu1_take(alu1_take),
		.result_out(result_out),
		.done_v(done_v), .done_ndx(done_ndx)
	);

endmodule

`default_nettype wire

//--- rtl/issue_pkg.sv
// ==============================
// Shared sizes, opcodes and record types for the ALU issue stage
// Every RTL file refers to these by scoped name, so compile this first
// ==============================
`default_nettype none

package issue_pkg;

	// ==============================
	// Sizes
	// ==============================

	// Depth of the circular issue queue
	localparam int QENTRIES = 8;
	// Number of ALUs fed by the selector
	localparam int NALU = 2;
	// Operand and result width
	localparam int DATA_W = 32;
	// A divide keeps its ALU busy for this many cycles
	localparam int DIV_CYCLES = 8;
	// Quotient bits the divider resolves in each of its cycles
	localparam int DIV_BITS = DATA_W / DIV_CYCLES;
	// Width of the dispatcher's instruction serial number
	localparam int TAG_W = 8;
	// Width of the writeback credit counter in the arbiter
	localparam int WB_CREDIT_W = 8;

	// ==============================
	// Types
	// ==============================

	typedef logic [2:0] que_ndx_t;
	typedef logic [QENTRIES-1:0] que_bitmask_t;
	// Selector output per entry, naming the ALU it was handed to
	typedef logic [1:0] islot_t;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_XOR  = 3'd3,
		OP_PASS = 3'd4,
		OP_DIV  = 3'd5
	} alu_op_t;

	// Decoded instruction as the dispatcher hands it over
	typedef struct packed {
		alu_op_t           op;
		logic              sync;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [TAG_W-1:0]  tag;
	} instr_t;

	// One issue queue slot
	typedef struct packed {
		logic   v;
		logic   issued;
		logic   done;
		logic   alu;
		instr_t instr;
	} iq_entry_t;

	// What the queue hands one ALU in the issue cycle
	typedef struct packed {
		logic     v;
		que_ndx_t ndx;
		instr_t   instr;
	} issue_t;

	// A finished result, carrying its queue slot back for done marking
	typedef struct packed {
		logic              v;
		que_ndx_t          ndx;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] value;
	} result_t;

endpackage

`default_nettype wire

//--- rtl/result_arbiter.sv
// ==============================
// Writeback arbiter for the two ALUs
// Takes one held result per cycle while writeback credit remains and
// reports its queue slot so the entry can be marked done
// ==============================
`timescale 1ns/10ps
`default_nettype none

module result_arbiter (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire issue_pkg::result_t   alu0_result,
	input  wire issue_pkg::result_t   alu1_result,
	input  wire                       wb_credit,
	output logic                      alu0_take,
	output logic                      alu1_take,
	output issue_pkg::result_t        result_out,
	output logic                      done_v,
	output issue_pkg::que_ndx_t       done_ndx
);

	// Slots granted by the consumer and not yet used
	logic [issue_pkg::WB_CREDIT_W-1:0] credits;
	// Set when ALU 1 wins the next tie
	logic prio;
	logic credit_ok;
	logic send;

	// Only credit already in the counter may be spent
	assign credit_ok = credits != '0;

	// Round robin between the ALUs when both hold a result
	assign alu0_take = credit_ok && alu0_result.v && (!alu1_result.v || !prio);
	assign alu1_take = credit_ok && alu1_result.v && (!alu0_result.v || prio);
	assign send = alu0_take || alu1_take;

	// The queue marks the entry done as its result goes out
	assign done_v = result_out.v;
	assign done_ndx = result_out.ndx;

	// ==============================
	// Credit count and output register
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= '0;
			prio <= 1'b0;
			result_out.v <= 1'b0;
		end else begin
			// A grant and a send in one cycle leave the count as it was
			case ({wb_credit, send})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
			if (alu0_take) begin
				result_out <= alu0_result;
				prio <= 1'b1;
			end else if (alu1_take) begin
				result_out <= alu1_result;
				prio <= 1'b0;
			end else begin
				result_out.v <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/issue_cases.txt
# op sync a b expected max_stall, one instruction per line, tag is the data line number from 0
# op 0 add 1 sub 2 and 3 xor 4 pass 5 div; sync, a, b, expected in hex; max_stall in cycles
5 0 00000064 00000007 0000000e 0
0 0 00000010 00000020 00000030 0
1 0 00000005 00000008 fffffffd 0
2 0 f0f0f0f0 ff00ff00 f000f000 0
3 0 aaaaaaaa 55555555 ffffffff 0
4 0 12345678 deadbeef 12345678 6
5 0 ffffffff 00000010 0fffffff 0
0 1 00000001 00000001 00000002 0
0 0 7fffffff 00000001 80000000 0
5 0 00001234 00000000 ffffffff 12
1 0 00000000 00000001 ffffffff 0
2 0 0000ffff 12345678 00005678 0
3 0 12345678 12345678 00000000 0
4 1 cafef00d 00000000 cafef00d 0
5 0 000003e8 0000000a 00000064 0
0 0 ffffffff 00000002 00000001 0
1 0 80000000 00000001 7fffffff 20
5 0 deadbeef 00000001 deadbeef 0
3 0 0f0f0f0f f0f0f0f0 ffffffff 0
2 1 ffffffff 0000abcd 0000abcd 0
0 0 00000123 00000456 00000579 0
5 0 00000007 00000009 00000000 0
4 0 00000000 ffffffff 00000000 0
1 0 0000abcd 0000abcd 00000000 9
5 1 00010000 00000100 00000100 0
0 0 00000003 00000004 00000007 0
3 0 ffff0000 0000ffff ffffffff 0
2 0 13579bdf 2468ace0 004088c0 3
5 0 fffffffe 00000003 55555554 0
0 0 00000000 00000000 00000000 0

//--- testbench/tb_issue_core.sv
// ==============================
// Testbench for the ALU issue stage
// Loads the case file, dispatches under credit flow control, throttles
// writeback credit and checks every result against its case by tag
// ==============================
`timescale 1ns/10ps
`default_nettype none

module tb_issue_core;

	localparam int MAX_CASES = 64;
	// Most writeback credits the consumer lets run ahead of the results
	localparam int WB_CAP = 4;
	localparam int SLOT_TIMEOUT = 500;
	localparam int DRAIN_TIMEOUT = 2000;
	localparam int RETIRE_TIMEOUT = 100;

	logic clk;
	logic rst_n;
	logic dispatch_v;
	issue_pkg::instr_t dispatch_in;
	logic dispatch_credit;
	logic wb_credit;
	issue_pkg::result_t result_out;

	// Case data and scoreboard, all indexed by tag
	issue_pkg::instr_t instr_q [0:MAX_CASES-1];
	issue_pkg::result_t expect_q [0:MAX_CASES-1];
	int stall_q [0:MAX_CASES-1];
	int seen_cnt [0:MAX_CASES-1];
	int out_pos [0:MAX_CASES-1];
	int ncases;

	// Each counter has exactly one process that writes it
	int dispatched;
	int credit_pulses;
	int grants;
	int results_seen;
	int stall_left;
	int value_errors;
	int other_errors;
	int mon_tag;
	int seed_init;

	issue_core UUT (
		.clk(clk),
		.rst_n(rst_n),
		.dispatch_v(dispatch_v),
		.dispatch_in(dispatch_in),
		.dispatch_credit(dispatch_credit),
		.wb_credit(wb_credit),
		.result_out(result_out)
	);

	always #4 clk = ~clk;

	// ==============================
	// Compare tasks
	// ==============================
	task automatic check_result(input string name, input issue_pkg::result_t expected,
		input issue_pkg::result_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t %s: expected tag %0d ndx %0d value %h, actual tag %0d ndx %0d value %h",
				$time, name, expected.tag, expected.ndx, expected.value,
				actual.tag, actual.ndx, actual.value);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[ERROR] %0t %s: expected %0d, actual %0d", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	// Single control bits, an unknown level counts as a mismatch
	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t %s: expected %b, actual %b", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	// Each data line becomes one case, its tag is its position among the data lines
	task automatic load_cases();
		int fd;
		int fields;
		int op_v;
		int sync_v;
		int stall_v;
		logic [31:0] a_v;
		logic [31:0] b_v;
		logic [31:0] exp_v;
		string line;
		ncases = 0;
		fd = $fopen("testbench/issue_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file testbench/issue_cases.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd) && ncases < MAX_CASES) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%h %h %h %h %h %d", op_v, sync_v, a_v, b_v, exp_v, stall_v);
				if (fields == 6) begin
					instr_q[ncases].op = issue_pkg::alu_op_t'(op_v[2:0]);
					instr_q[ncases].sync = sync_v[0];
					instr_q[ncases].a = a_v;
					instr_q[ncases].b = b_v;
					instr_q[ncases].tag = ncases[7:0];
					// The tail starts at slot 0, so dispatch order fixes the slot
					expect_q[ncases].v = 1'b1;
					expect_q[ncases].ndx = ncases[2:0];
					expect_q[ncases].tag = ncases[7:0];
					expect_q[ncases].value = exp_v;
					stall_q[ncases] = stall_v;
					ncases++;
				end
			end
		end
		$fclose(fd);
	endtask

	// Results older than a sync must all leave before any younger one
	task automatic check_sync_order();
		int last_old;
		int first_young;
		for (int s = 0; s < ncases; s++) begin
			if (instr_q[s].sync) begin
				last_old = -1;
				first_young = 1 << 30;
				for (int t = 0; t < s; t++) begin
					if (seen_cnt[t] > 0 && out_pos[t] > last_old)
						last_old = out_pos[t];
				end
				for (int t = s + 1; t < ncases; t++) begin
					if (seen_cnt[t] > 0 && out_pos[t] < first_young)
						first_young = out_pos[t];
				end
				if (last_old > first_young) begin
					$display("A result younger than sync tag %0d left before an older result", s);
					other_errors++;
				end
			end
		end
	endtask

	// The first divide followed by a plain simple op must be overtaken by it,
	// which only happens if the other ALU keeps issuing during the divide
	task automatic check_overtake();
		int d;
		d = -1;
		for (int n = ncases - 2; n >= 0; n--) begin
			if (instr_q[n].op == issue_pkg::OP_DIV && !instr_q[n].sync &&
				instr_q[n+1].op != issue_pkg::OP_DIV && !instr_q[n+1].sync)
				d = n;
		end
		if (d < 0) begin
			$display("The case file has no divide followed by a simple op");
			other_errors++;
		end else if (seen_cnt[d] > 0 && seen_cnt[d+1] > 0 && out_pos[d+1] > out_pos[d]) begin
			$display("The simple op after divide tag %0d did not overtake the divide", d);
			other_errors++;
		end
	endtask

	// ==============================
	// Output monitor, sampled mid cycle
	// ==============================
	always @(negedge clk) begin
		if (rst_n) begin
			if (wb_credit)
				grants++;
			if (dispatch_credit)
				credit_pulses++;
			if (result_out.v) begin
				mon_tag = result_out.tag;
				if (mon_tag >= ncases) begin
					$display("At %0t a result carried tag %0d, which was never dispatched",
						$time, mon_tag);
					other_errors++;
				end else begin
					check_result("result_out", expect_q[mon_tag], result_out);
					if (seen_cnt[mon_tag] == 0)
						out_pos[mon_tag] = results_seen;
					seen_cnt[mon_tag]++;
				end
				results_seen++;
			end
			// Grants stop during a stall, so this also covers used up credit
			if (results_seen > grants) begin
				$display("At %0t more results left than writeback credits were granted", $time);
				other_errors++;
			end
			// A slot is only free once its result has left, so an early credit
			// would let more than QENTRIES instructions live in the queue
			if (credit_pulses > results_seen) begin
				$display("At %0t a dispatch credit came back before its result had left",
					$time);
				other_errors++;
			end
		end
	end

	// ==============================
	// Writeback credit driver
	// ==============================
	always @(posedge clk) begin
		if (!rst_n) begin
			wb_credit <= 1'b0;
			stall_left = 0;
		end else begin
			// A case with a stall bound opens a window of withheld credit when accepted
			if (dispatch_v && dispatch_in.tag < ncases && stall_q[dispatch_in.tag] > 0)
				stall_left = 1 + ($urandom % stall_q[dispatch_in.tag]);
			if (stall_left > 0) begin
				wb_credit <= 1'b0;
				stall_left--;
			end else begin
				wb_credit <= (grants - results_seen) < WB_CAP;
			end
		end
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int i;
		int wait_cnt;
		logic timed_out;
		clk = 1'b0;
		rst_n = 1'b0;
		dispatch_v = 1'b0;
		dispatch_in = '0;
		wb_credit = 1'b0;
		timed_out = 1'b0;
		seed_init = $urandom(16);
		load_cases();
		if (ncases == 0) begin
			$display("No cases were loaded from the case file");
			other_errors++;
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("dispatch_credit after reset", 1'b0, dispatch_credit);
		check_bit("result_out.v after reset", 1'b0, result_out.v);

		// Dispatch only while the credit count allows it
		i = 0;
		wait_cnt = 0;
		while (i < ncases && !timed_out) begin
			@(posedge clk);
			if (dispatched - credit_pulses >= issue_pkg::QENTRIES) begin
				dispatch_v <= 1'b0;
				wait_cnt++;
				if (wait_cnt > SLOT_TIMEOUT) begin
					$display("Timeout: no dispatch credit came back for %0d cycles", SLOT_TIMEOUT);
					other_errors++;
					timed_out = 1'b1;
				end
			end else if ($urandom % 5 == 0) begin
				// An idle dispatch cycle now and then
				dispatch_v <= 1'b0;
			end else begin
				dispatch_v <= 1'b1;
				dispatch_in <= instr_q[i];
				dispatched++;
				i++;
				wait_cnt = 0;
			end
		end
		@(posedge clk);
		dispatch_v <= 1'b0;

		wait_cnt = 0;
		while (!timed_out && results_seen < ncases) begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > DRAIN_TIMEOUT) begin
				$display("Timeout: only %0d of %0d results arrived", results_seen, ncases);
				other_errors++;
				timed_out = 1'b1;
			end
		end

		// The last entries still have to retire and return their credit
		wait_cnt = 0;
		while (!timed_out && credit_pulses < dispatched) begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > RETIRE_TIMEOUT) begin
				$display("Timeout: the queue did not return all dispatch credits");
				other_errors++;
				timed_out = 1'b1;
			end
		end

		check_count("dispatched instructions", ncases, dispatched);
		check_count("dispatch_credit pulses", dispatched, credit_pulses);
		for (int t = 0; t < ncases; t++)
			check_count($sformatf("results with tag %0d", t), 1, seen_cnt[t]);
		check_sync_order();
		check_overtake();

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
